//--- design/hit_reporter.sv
module hit_reporter import md5_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    md5_cfg_if.user              cfg,
    input  logic                 hit_valid,
    input  logic [WORD_W-1:0]    hit_nonce,
    output logic                 found,
    output logic [WORD_W-1:0]    found_nonce,
    output logic [HIT_CNT_W-1:0] hit_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            found       <= 1'b0;
            found_nonce <= '0;
            hit_count   <= '0;
        end else if (cfg.clear) begin
            found       <= 1'b0;
            found_nonce <= '0;
            hit_count   <= '0;
        end else if (hit_valid) begin
            // Only the first hit is kept
            if (!found) begin
                found       <= 1'b1;
                found_nonce <= hit_nonce;
            end
            if (hit_count != '1) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

endmodule

//--- design/md5_cfg_if.sv
interface md5_cfg_if import md5_pkg::*; ();

    logic [DIGEST_W-1:0] target;
    logic [DIGEST_W-1:0] mask;
    logic                enable;
    // Single-cycle pulse
    logic                clear;

    modport cfg (
        output target,
        output mask,
        output enable,
        output clear
    );

    modport user (
        input target,
        input mask,
        input enable,
        input clear
    );

endinterface

//--- design/md5_cfg_regs.sv
module md5_cfg_regs import md5_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_wr,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [WORD_W-1:0]     reg_wdata,
    md5_cfg_if.cfg                cfg
);

    logic [DIGEST_W/WORD_W-1:0][WORD_W-1:0] target_q;
    logic [DIGEST_W/WORD_W-1:0][WORD_W-1:0] mask_q;
    logic                                   enable_q;
    logic                                   clear_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q <= '0;
            mask_q   <= '0;
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    REG_TARGET0, REG_TARGET1, REG_TARGET2, REG_TARGET3: begin
                        target_q[reg_addr[1:0]] <= reg_wdata;
                    end
                    REG_MASK0, REG_MASK1, REG_MASK2, REG_MASK3: begin
                        mask_q[reg_addr[1:0]] <= reg_wdata;
                    end
                    REG_CTRL: begin
                        enable_q <= reg_wdata[0];
                        clear_q  <= reg_wdata[1];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cfg.target = target_q;
    assign cfg.mask   = mask_q;
    assign cfg.enable = enable_q;
    assign cfg.clear  = clear_q;

    // Host must drive a real address with every write strobe
    a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr |-> !$isunknown(reg_addr));

endmodule

//--- design/md5_engine.sv
module md5_engine import md5_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    md5_cfg_if.user           cfg,
    output logic              md5_block_ready,
    input  logic              md5_block_valid,
    input  md5_block_u        md5_block_data,
    output logic              result_valid,
    output logic [WORD_W-1:0] result_nonce
);

    md5_block_u          block_q;
    logic                busy;
    logic                final_step;
    logic [ROUND_W-1:0]  round;
    logic [WORD_W-1:0]   a;
    logic [WORD_W-1:0]   b;
    logic [WORD_W-1:0]   c;
    logic [WORD_W-1:0]   d;
    logic [WORD_W-1:0]   f;
    logic [3:0]          g;
    logic [4:0]          s;
    logic [WORD_W-1:0]   m_word;
    logic [WORD_W-1:0]   sum;
    logic [WORD_W-1:0]   rot;
    logic [DIGEST_W-1:0] digest;
    logic                match;
    logic                accept;

    assign md5_block_ready = !busy && cfg.enable;
    assign accept          = md5_block_valid && md5_block_ready;

    // Round function and message word index per group of 16
    always_comb begin
        case (round[5:4])
            2'd0: begin
                f = (b & c) | (~b & d);
                g = round[3:0];
            end
            2'd1: begin
                f = (b & d) | (c & ~d);
                g = 4'(5 * round + 1);
            end
            2'd2: begin
                f = b ^ c ^ d;
                g = 4'(3 * round + 5);
            end
            default: begin
                f = c ^ (b | ~d);
                g = 4'(7 * round);
            end
        endcase
        m_word = block_q.words[g];
        sum    = a + f + md5_k(round) + m_word;
        s      = md5_s(round);
        rot    = (sum << s) | (sum >> (WORD_W - s));
    end

    // Digest word A sits in the low bits like target word 0
    assign digest = {d + MD5_INIT_D, c + MD5_INIT_C, b + MD5_INIT_B, a + MD5_INIT_A};
    assign match  = ((digest ^ cfg.target) & cfg.mask) == '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            final_step   <= 1'b0;
            round        <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                round <= '0;
            end else if (final_step) begin
                final_step   <= 1'b0;
                busy         <= 1'b0;
                result_valid <= match;
            end else if (busy) begin
                round <= round + 1'b1;
                if (round == ROUND_W'(NUM_ROUNDS - 1)) begin
                    final_step <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            block_q <= md5_block_data;
            a       <= MD5_INIT_A;
            b       <= MD5_INIT_B;
            c       <= MD5_INIT_C;
            d       <= MD5_INIT_D;
        end else if (busy && !final_step) begin
            a <= d;
            b <= b + rot;
            c <= b;
            d <= c;
        end
    end

    assign result_nonce = block_q.fields.nonce;

    // Hit pulse rises on the 65th edge after its block was taken
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(accept, NUM_ROUNDS + 2));

endmodule

//--- design/md5_engine_units.sv
module md5_engine_units import md5_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    md5_cfg_if.user           cfg,
    output logic              md5_block_ready,
    input  logic              md5_block_valid,
    input  md5_block_u        md5_block_data,
    output logic              hit_valid,
    output logic [WORD_W-1:0] hit_nonce
);

    logic [NUM_ENGINES-1:0] sel;
    logic [NUM_ENGINES-1:0] eng_ready;
    logic [NUM_ENGINES-1:0] eng_valid;
    logic [NUM_ENGINES-1:0] eng_hit;
    logic [WORD_W-1:0]      eng_nonce [NUM_ENGINES];
    logic                   xfer;

    // Busy selected engine stalls the input even when others are free
    assign md5_block_ready = |(eng_ready & sel);
    assign xfer            = md5_block_ready && md5_block_valid;
    assign eng_valid       = sel & {NUM_ENGINES{md5_block_valid}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= NUM_ENGINES'(1);
        end else if (xfer) begin
            sel <= {sel[NUM_ENGINES-2:0], sel[NUM_ENGINES-1]};
        end
    end

    for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
        md5_engine u_engine (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg             (cfg),
            .md5_block_ready (eng_ready[i]),
            .md5_block_valid (eng_valid[i]),
            .md5_block_data  (md5_block_data),
            .result_valid    (eng_hit[i]),
            .result_nonce    (eng_nonce[i])
        );
    end

    // Collector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= |eng_hit;
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_ENGINES; j++) begin
            if (eng_hit[j]) begin
                hit_nonce <= eng_nonce[j];
            end
        end
    end

    // Equal latency and one accept per cycle keep finishes apart
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(eng_hit));

endmodule

//--- design/md5_pkg.sv
package md5_pkg;

    localparam int NUM_ENGINES = 4;
    localparam int BLOCK_W     = 512;
    localparam int DIGEST_W    = 128;
    localparam int WORD_W      = 32;
    localparam int NUM_ROUNDS  = 64;
    localparam int ROUND_W     = $clog2(NUM_ROUNDS);
    localparam int HIT_CNT_W   = 8;
    localparam int REG_ADDR_W  = 4;

    localparam logic [REG_ADDR_W-1:0] REG_TARGET0 = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_TARGET1 = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_TARGET2 = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_TARGET3 = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_MASK0   = 4'd4;
    localparam logic [REG_ADDR_W-1:0] REG_MASK1   = 4'd5;
    localparam logic [REG_ADDR_W-1:0] REG_MASK2   = 4'd6;
    localparam logic [REG_ADDR_W-1:0] REG_MASK3   = 4'd7;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 4'd8;

    // Chaining values of the single block
    localparam logic [WORD_W-1:0] MD5_INIT_A = 32'h67452301;
    localparam logic [WORD_W-1:0] MD5_INIT_B = 32'hefcdab89;
    localparam logic [WORD_W-1:0] MD5_INIT_C = 32'h98badcfe;
    localparam logic [WORD_W-1:0] MD5_INIT_D = 32'h10325476;

    localparam logic [WORD_W-1:0] MD5_K_TABLE [NUM_ROUNDS] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // Four shift amounts per round group, repeating
    localparam logic [4:0] MD5_S_TABLE [16] = '{
        7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21
    };

    typedef union packed {
        logic [BLOCK_W/WORD_W-1:0][WORD_W-1:0] words;
        struct packed {
            logic [BLOCK_W-WORD_W-1:0] payload;
            logic [WORD_W-1:0]         nonce;
        } fields;
    } md5_block_u;

    function automatic logic [WORD_W-1:0] md5_k(input logic [ROUND_W-1:0] idx);
        return MD5_K_TABLE[idx];
    endfunction

    function automatic logic [4:0] md5_s(input logic [ROUND_W-1:0] idx);
        return MD5_S_TABLE[{idx[5:4], idx[1:0]}];
    endfunction

endpackage

//--- design/md5_search_top.sv
module md5_search_top import md5_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_wr,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic [WORD_W-1:0]     reg_wdata,
    input  logic                  md5_block_valid,
    output logic                  md5_block_ready,
    input  logic [BLOCK_W-1:0]    md5_block_data,
    output logic                  found,
    output logic [WORD_W-1:0]     found_nonce,
    output logic [HIT_CNT_W-1:0]  hit_count
);

    logic              hit_valid;
    logic [WORD_W-1:0] hit_nonce;

    md5_cfg_if cfg_bus ();

    md5_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .cfg       (cfg_bus.cfg)
    );

    md5_engine_units u_engine_units (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg_bus.user),
        .md5_block_ready (md5_block_ready),
        .md5_block_valid (md5_block_valid),
        .md5_block_data  (md5_block_data),
        .hit_valid       (hit_valid),
        .hit_nonce       (hit_nonce)
    );

    hit_reporter u_hit_reporter (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_bus.user),
        .hit_valid   (hit_valid),
        .hit_nonce   (hit_nonce),
        .found       (found),
        .found_nonce (found_nonce),
        .hit_count   (hit_count)
    );

endmodule

//--- tb/tb_md5_search.sv
module tb_md5_search import md5_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 300;

    logic                  clk;
    logic                  rst_n;
    logic                  reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [WORD_W-1:0]     reg_wdata;
    logic                  md5_block_valid;
    logic                  md5_block_ready;
    md5_block_u            md5_block_data;
    logic                  found;
    logic [WORD_W-1:0]     found_nonce;
    logic [HIT_CNT_W-1:0]  hit_count;

    int                    seed = 32'h1a7e4578;
    logic                  saw_stall;
    md5_block_u            blk;
    logic [WORD_W-1:0]     first_nonce;

    md5_search_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_wr          (reg_wr),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .md5_block_valid (md5_block_valid),
        .md5_block_ready (md5_block_ready),
        .md5_block_data  (md5_block_data),
        .found           (found),
        .found_nonce     (found_nonce),
        .hit_count       (hit_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_nonce(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_count(input logic [HIT_CNT_W-1:0] got,
                               input logic [HIT_CNT_W-1:0] exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // Mask registers follow the target registers
    task automatic load_digest(input logic [REG_ADDR_W-1:0] base, input logic [DIGEST_W-1:0] value);
        for (int i = 0; i < DIGEST_W / WORD_W; i++) begin
            write_reg(base + REG_ADDR_W'(i), value[i*WORD_W +: WORD_W]);
        end
    endtask

    // Clear pulse reaches the reporter one cycle after the write
    task automatic clear_search();
        write_reg(REG_CTRL, 32'h3);
        repeat (2) @(negedge clk);
    endtask

    task automatic send_block(input md5_block_u data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        md5_block_valid <= 1'b1;
        md5_block_data  <= data;
        @(negedge clk);
        while (!md5_block_ready) begin
            saw_stall = 1'b1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for the DUT to accept a block");
            end
            @(negedge clk);
        end
        @(posedge clk);
        md5_block_valid <= 1'b0;
    endtask

    task automatic wait_found();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!found) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for found to rise");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_hits(input logic [HIT_CNT_W-1:0] target_count);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hit_count != target_count) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for the expected number of hits");
            end
            @(negedge clk);
        end
    endtask

    task automatic random_block(output md5_block_u data);
        for (int i = 0; i < BLOCK_W / WORD_W; i++) begin
            data.words[i] = $random(seed);
        end
    endtask

    // MD5 of abc is 900150983cd24fb0d6963f7d28e17f72 with word A in the low bits
    task automatic known_answer_match();
        load_digest(REG_TARGET0, {32'h727fe128, 32'h7d3f96d6, 32'hb04fd23c, 32'h98500190});
        load_digest(REG_MASK0, '1);
        write_reg(REG_CTRL, 32'h1);
        blk           = '0;
        blk.words[0]  = 32'h80636261;
        blk.words[14] = 32'd24;
        send_block(blk);
        wait_found();
        check_nonce(found_nonce, 32'h80636261, "found_nonce for abc");
        check_count(hit_count, 8'd1, "hit_count for abc");
        clear_search();
    endtask

    task automatic empty_string_miss();
        blk          = '0;
        blk.words[0] = 32'h00000080;
        send_block(blk);
        repeat (100) @(negedge clk);
        check_flag(found, 1'b0, "found for empty string");
        check_count(hit_count, 8'd0, "hit_count for empty string");
    endtask

    task automatic mask_zero_hits();
        load_digest(REG_MASK0, '0);
        for (int n = 0; n < 5; n++) begin
            random_block(blk);
            if (n == 0) begin
                first_nonce = blk.fields.nonce;
            end
            send_block(blk);
        end
        wait_hits(8'd5);
        check_nonce(found_nonce, first_nonce, "found_nonce after five hits");
    endtask

    task automatic backpressure_burst();
        clear_search();
        saw_stall = 1'b0;
        for (int n = 0; n < 8; n++) begin
            random_block(blk);
            send_block(blk);
        end
        check_flag(saw_stall, 1'b1, "ready low with all engines busy");
        wait_hits(8'd8);
        repeat (80) @(negedge clk);
        check_count(hit_count, 8'd8, "hit_count after burst");
    endtask

    task automatic clear_and_disable();
        clear_search();
        check_flag(found, 1'b0, "found after clear");
        check_count(hit_count, 8'd0, "hit_count after clear");
        write_reg(REG_CTRL, 32'h0);
        random_block(blk);
        @(posedge clk);
        md5_block_valid <= 1'b1;
        md5_block_data  <= blk;
        repeat (20) begin
            @(negedge clk);
            check_flag(md5_block_ready, 1'b0, "ready with enable cleared");
        end
        @(posedge clk);
        md5_block_valid <= 1'b0;
    endtask

    initial begin
        rst_n           = 1'b0;
        reg_wr          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        md5_block_valid = 1'b0;
        md5_block_data  = '0;
        saw_stall       = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(md5_block_ready, 1'b0, "ready after reset");
        check_flag(found, 1'b0, "found after reset");
        check_count(hit_count, 8'd0, "hit_count after reset");
        known_answer_match();
        empty_string_miss();
        mask_zero_hits();
        backpressure_burst();
        clear_and_disable();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verilog.f
design/md5_pkg.sv
design/md5_cfg_if.sv
design/md5_cfg_regs.sv
design/md5_engine.sv
design/md5_engine_units.sv
design/hit_reporter.sv
design/md5_search_top.sv
tb/tb_md5_search.sv
